// ==== hw/core_pkg.sv ====
package core_pkg;

    // Instruction address and raw instruction word
    typedef logic [7:0]  pc_t;
    typedef logic [15:0] word_t;

    typedef enum logic [2:0] {
        op_nop  = 3'd0,
        op_addi = 3'd1,
        op_jmp  = 3'd2,
        op_bnz  = 3'd3,
        op_trap = 3'd4,
        op_halt = 3'd7
    } opcode_t;

    // ALU form carries a signed immediate that is added to the accumulator
    typedef struct packed {
        opcode_t            opcode;
        logic signed [12:0] imm;
    } alu_view_t;

    // Control form carries an absolute target address
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rsvd;
        pc_t        target;
    } ctrl_view_t;

    // Both views keep the opcode in the top three bits
    typedef union packed {
        alu_view_t  alu_view;
        ctrl_view_t ctrl_view;
    } inst_u;

    // One fetched instruction with the address it came from
    typedef struct packed {
        pc_t   pc;
        inst_u inst;
    } fetch_entry_t;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } flush_req_t;

    // Cascade outputs, ordered from the oldest stage boundary to the youngest
    typedef struct packed {
        logic to_ex_wb;
        logic to_id_ex;
        logic to_fifo;
        logic to_if;
    } flush_vec_t;

endpackage

// ==== hw/fetch_unit.sv ====
module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   imem_we,
    input  core_pkg::pc_t          imem_addr,
    input  core_pkg::word_t        imem_wdata,
    input  logic                   start,
    input  logic                   full,
    input  core_pkg::flush_vec_t   flush,
    input  core_pkg::pc_t          redirect_pc,
    output logic                   push,
    output core_pkg::fetch_entry_t entry
);
    import core_pkg::*;

    localparam pc_t RESET_PC = 8'h00;

    word_t        imem [IMEM_DEPTH];
    pc_t          pc_q;
    logic         if1_valid;
    fetch_entry_t if1_q;
    logic         advance;

    // if0 reads memory whenever if1 is free or is being drained into the FIFO
    assign advance = start && (!if1_valid || !full);

    assign push  = if1_valid && !full;
    assign entry = if1_q;

    // The load port writes the program before start goes high
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
        if (advance) begin
            if1_q.pc   <= pc_q;
            if1_q.inst <= inst_u'(imem[pc_q]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q      <= RESET_PC;
            if1_valid <= 1'b0;
        end else if (flush.to_if) begin
            // The word in if1 is on the wrong path, so restart from the target
            pc_q      <= redirect_pc;
            if1_valid <= 1'b0;
        end else if (advance) begin
            // No prediction here, fetch simply falls through
            pc_q      <= pc_q + pc_t'(1);
            if1_valid <= 1'b1;
        end
    end

    // A word stalled by a full FIFO stays in if1 until it can be pushed
    a_hold_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (if1_valid && full && !flush.to_if) |=> (if1_valid && (entry == $past(entry)))
    ) else $error("fetch_unit: if1 word changed while the FIFO was full");

endmodule

// ==== hw/inst_fifo.sv ====
module inst_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  core_pkg::fetch_entry_t wentry,
    input  logic                   pop,
    input  core_pkg::flush_vec_t   flush,
    output core_pkg::fetch_entry_t rentry,
    output logic                   full,
    output logic                   empty
);
    import core_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fetch_entry_t     slots [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Show-ahead head, the oldest entry is always on rentry
    assign rentry = slots[rd_ptr];

    // A flush wins over anything pushed or popped in the same cycle
    assign do_push = push && !full && !flush.to_fifo;
    assign do_pop  = pop && !empty && !flush.to_fifo;

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= wentry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush.to_fifo) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Both strobes come from other blocks, which must respect the levels
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("inst_fifo: pop while empty");
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("inst_fifo: push while full");

endmodule

// ==== hw/exec_pipe.sv ====
module exec_pipe #(
    parameter core_pkg::pc_t TRAP_VECTOR = 8'hF0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::fetch_entry_t rentry,
    input  logic                   empty,
    input  logic                   hold,
    input  core_pkg::flush_vec_t   flush,
    output logic                   pop,
    output core_pkg::flush_req_t   id_req,
    output core_pkg::flush_req_t   ex_req,
    output core_pkg::flush_req_t   wb_req,
    output logic                   retire_valid,
    output core_pkg::pc_t          retire_pc,
    output core_pkg::word_t        retire_acc,
    output logic                   halted
);
    import core_pkg::*;

    logic         id_valid;
    logic         ex_valid;
    logic         wb_valid;
    fetch_entry_t id_q;
    fetch_entry_t ex_q;
    fetch_entry_t wb_q;
    word_t        acc_q;

    logic         advance;
    logic         wb_halt;
    logic         kill_id;
    logic         kill_ex;
    logic         kill_wb;
    opcode_t      id_op;
    opcode_t      ex_op;
    opcode_t      wb_op;
    word_t        ex_imm;

    // The opcode sits in the same bits of both views
    assign id_op = id_q.inst.ctrl_view.opcode;
    assign ex_op = ex_q.inst.alu_view.opcode;
    assign wb_op = wb_q.inst.ctrl_view.opcode;

    assign ex_imm = {{3{ex_q.inst.alu_view.imm[12]}}, ex_q.inst.alu_view.imm};

    // All three stages move together or not at all
    assign advance = !hold && !halted;
    assign pop     = !empty && advance;
    assign wb_halt = wb_valid && (wb_op == op_halt);

    // A stage that redirects survives and only the younger slots are dropped
    assign kill_id = flush.to_fifo || wb_halt;
    assign kill_ex = flush.to_id_ex || wb_halt;
    assign kill_wb = flush.to_ex_wb || wb_halt;

    // Requests are raised only in the cycle the stage actually moves on
    assign id_req.valid  = advance && id_valid && (id_op == op_jmp);
    assign id_req.target = id_q.inst.ctrl_view.target;

    // acc_q already holds the result of every older addi at this point
    assign ex_req.valid  = advance && ex_valid && (ex_op == op_bnz) && (acc_q != '0);
    assign ex_req.target = ex_q.inst.ctrl_view.target;

    assign wb_req.valid  = advance && wb_valid && (wb_op == op_trap);
    assign wb_req.target = TRAP_VECTOR;

    assign retire_valid = wb_valid && !hold;
    assign retire_pc    = wb_q.pc;
    assign retire_acc   = acc_q;

    always_ff @(posedge clk) begin
        if (advance) begin
            id_q <= rentry;
            ex_q <= id_q;
            wb_q <= ex_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
            acc_q    <= '0;
            halted   <= 1'b0;
        end else if (advance) begin
            id_valid <= pop && !kill_id;
            ex_valid <= id_valid && !kill_ex;
            wb_valid <= ex_valid && !kill_wb;
            // The add commits as the instruction leaves ex
            if (ex_valid && !kill_wb && (ex_op == op_addi)) begin
                acc_q <= acc_q + ex_imm;
            end
            if (wb_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // Once halted, the pipe stays halted and nothing else retires
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> (halted && !retire_valid)
    ) else $error("exec_pipe: retirement after halt");

endmodule

// ==== hw/hazard_unit.sv ====
module hazard_unit (
    input  core_pkg::flush_req_t id_req,
    input  core_pkg::flush_req_t ex_req,
    input  core_pkg::flush_req_t wb_req,
    output core_pkg::flush_vec_t flush,
    output core_pkg::pc_t        redirect_pc
);
    import core_pkg::*;

    // An older stage's request kills every stage younger than itself
    assign flush.to_ex_wb = wb_req.valid ? 1'b1 : 1'b0;

    assign flush.to_id_ex = wb_req.valid ? 1'b1 :
                            ex_req.valid ? 1'b1 : 1'b0;

    assign flush.to_fifo  = wb_req.valid ? 1'b1 :
                            ex_req.valid ? 1'b1 :
                            id_req.valid ? 1'b1 : 1'b0;

    // Fetch is always refilled from the redirect when the FIFO is flushed
    assign flush.to_if    = flush.to_fifo;

    // Oldest requester supplies the target
    always_comb begin
        if (wb_req.valid) begin
            redirect_pc = wb_req.target;
        end else if (ex_req.valid) begin
            redirect_pc = ex_req.target;
        end else begin
            redirect_pc = id_req.target;
        end
    end

    // Whenever the pipe is cleared behind ex, fetch must be redirected too
    always_comb begin
        a_if_follows_id_ex: assert final (!flush.to_id_ex || flush.to_if)
            else $error("hazard_unit: to_id_ex raised without to_if");
    end

endmodule

// ==== hw/core_frontend_top.sv ====
module core_frontend_top #(
    parameter int            IMEM_DEPTH  = 256,
    parameter int            FIFO_DEPTH  = 4,
    parameter core_pkg::pc_t TRAP_VECTOR = 8'hF0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            imem_we,
    input  core_pkg::pc_t   imem_addr,
    input  core_pkg::word_t imem_wdata,
    input  logic            start,
    input  logic            hold,
    output logic            retire_valid,
    output core_pkg::pc_t   retire_pc,
    output core_pkg::word_t retire_acc,
    output logic            halted
);
    import core_pkg::*;

    logic         push;
    logic         pop;
    logic         full;
    logic         empty;
    fetch_entry_t wentry;
    fetch_entry_t rentry;
    flush_req_t   id_req;
    flush_req_t   ex_req;
    flush_req_t   wb_req;
    flush_vec_t   flush;
    pc_t          redirect_pc;

    // Producer side
    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .start       (start),
        .full        (full),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .push        (push),
        .entry       (wentry)
    );

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (push),
        .wentry (wentry),
        .pop    (pop),
        .flush  (flush),
        .rentry (rentry),
        .full   (full),
        .empty  (empty)
    );

    // Consumer side
    exec_pipe #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .rentry       (rentry),
        .empty        (empty),
        .hold         (hold),
        .flush        (flush),
        .pop          (pop),
        .id_req       (id_req),
        .ex_req       (ex_req),
        .wb_req       (wb_req),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_acc   (retire_acc),
        .halted       (halted)
    );

    hazard_unit u_hazard (
        .id_req      (id_req),
        .ex_req      (ex_req),
        .wb_req      (wb_req),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== tests/tb_core_frontend.sv ====
module tb_core_frontend;
    import core_pkg::*;

    localparam int MAX_CYCLES   = 2000;
    localparam int QUIET_CYCLES = 10;
    localparam int SAMPLE_DELAY = 5;

    logic   clk;
    logic   rst_n;
    logic   imem_we;
    pc_t    imem_addr;
    word_t  imem_wdata;
    logic   start;
    logic   hold;
    logic   retire_valid;
    pc_t    retire_pc;
    word_t  retire_acc;
    logic   halted;

    pc_t    load_addr [$];
    word_t  load_word [$];
    pc_t    exp_pc [$];
    word_t  exp_acc [$];
    int     exp_idx;
    integer seed = 61;

    core_frontend_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .start        (start),
        .hold         (hold),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_acc   (retire_acc),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Trace lines are "L addr word" for the program and "R pc acc" for retirements
    task automatic read_trace();
        integer           fd;
        integer           code;
        logic [7:0]       kind;
        logic [8*96-1:0]  line;
        logic [15:0]      a;
        logic [15:0]      b;
        logic             done_reading;
        fd = $fopen("tests/core_trace.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the trace file tests/core_trace.txt");
        end
        done_reading = 1'b0;
        while (!done_reading) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done_reading = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "L") begin
                code = $fscanf(fd, "%h %h", a, b);
                load_addr.push_back(pc_t'(a));
                load_word.push_back(b);
            end else if (kind == "R") begin
                code = $fscanf(fd, "%h %h", a, b);
                exp_pc.push_back(pc_t'(a));
                exp_acc.push_back(b);
            end else begin
                report_failure("The trace file holds a line of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        start = 1'b0;
        hold  = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!retire_valid && !halted)
            else report_failure("retire_valid or halted is high right after reset");
    endtask

    // Memory has no reset, so one load serves both runs
    task automatic load_program();
        for (int i = 0; i < load_addr.size(); i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = load_addr[i];
            imem_wdata = load_word[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic check_retire();
        assert (exp_idx < exp_pc.size())
            else report_failure($sformatf("Unexpected retirement at pc %h after the last one",
                                          retire_pc));
        assert (retire_pc === exp_pc[exp_idx])
            else report_failure($sformatf("[ERROR] retire_pc expected %h actual %h",
                                          exp_pc[exp_idx], retire_pc));
        assert (retire_acc === exp_acc[exp_idx])
            else report_failure($sformatf("[ERROR] retire_acc expected %h actual %h",
                                          exp_acc[exp_idx], retire_acc));
        exp_idx++;
    endtask

    // Hold changes on the falling edge and the outputs are read a quarter cycle later
    task automatic run_program(input logic use_hold);
        int   cycles;
        logic seen_halt;
        cycles    = 0;
        seen_halt = 1'b0;
        exp_idx   = 0;
        @(negedge clk);
        start = 1'b1;
        while (!seen_halt && cycles < MAX_CYCLES) begin
            @(negedge clk);
            hold = use_hold ? (($random(seed) & 3) == 0) : 1'b0;
            #SAMPLE_DELAY;
            if (retire_valid) begin
                check_retire();
            end
            seen_halt = halted;
            cycles++;
        end
        if (!seen_halt) begin
            report_failure("Timed out after 2000 cycles waiting for halted");
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            hold = use_hold ? (($random(seed) & 3) == 0) : 1'b0;
            #SAMPLE_DELAY;
            assert (!retire_valid)
                else report_failure("An instruction retired after halted was set");
            assert (halted)
                else report_failure("halted dropped before reset");
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        hold       = 1'b0;
        exp_idx    = 0;
        read_trace();
        apply_reset();
        load_program();
        // Reference run with hold low, then the same program under random back-pressure
        run_program(1'b0);
        assert (exp_idx == exp_pc.size())
            else report_failure("The run without hold retired fewer instructions than expected");
        apply_reset();
        run_program(1'b1);
        if (exp_idx == exp_pc.size()) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure("The run with random hold retired fewer instructions than expected");
        end
    end

endmodule

// ==== tests/core_trace.txt ====
# L addr word : program word written through the load port
# R pc acc    : expected retirement in order, pc and accumulator after it
L 00 2001
L 01 2002
L 02 0000
L 03 2005
L 04 4010
L 05 2064
L 06 2064
L 10 6020
L 11 2064
L 12 2064
L 20 3FF8
L 21 6030
L 22 2003
L 23 8000
L 24 4050
L 25 4050
L 50 2064
L 51 E000
L F0 2002
L F1 E000
L F2 2064
R 00 0001
R 01 0003
R 02 0003
R 03 0008
R 04 0008
R 10 0008
R 20 0000
R 21 0000
R 22 0003
R 23 0003
R F0 0005
R F1 0005

// ==== tb.f ====
hw/core_pkg.sv
hw/fetch_unit.sv
hw/inst_fifo.sv
hw/exec_pipe.sv
hw/hazard_unit.sv
hw/core_frontend_top.sv
tests/tb_core_frontend.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_core_frontend
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulator status is ignored and the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
